//--- source/rv_pkg.sv
// shared widths, opcodes, ALU codes and the instruction word type for the RV32I core
// imported by every core module
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000; // first fetch address

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    // load/store funct3 size codes
    localparam logic [2:0] SIZE_B  = 3'b000;
    localparam logic [2:0] SIZE_H  = 3'b001;
    localparam logic [2:0] SIZE_W  = 3'b010;
    localparam logic [2:0] SIZE_BU = 3'b100;
    localparam logic [2:0] SIZE_HU = 3'b101;

    // sequencer states
    localparam int         STATE_W      = 3;
    localparam logic [2:0] ST_FETCH_REQ = 3'd0;
    localparam logic [2:0] ST_FETCH_REL = 3'd1;
    localparam logic [2:0] ST_EXEC      = 3'd2;
    localparam logic [2:0] ST_MEM_REQ   = 3'd3;
    localparam logic [2:0] ST_MEM_REL   = 3'd4;
    localparam logic [2:0] ST_HALT      = 3'd5;

    // one instruction word, read as R-format or I-format fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_t;

endpackage

//--- source/reg_file.sv
// 32 x XLEN integer register file, two combinational reads and one write
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];   // x0 reads zero
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- source/inst_decoder.sv
// instruction decoder, splits fields, builds immediates and control flags
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
    input  inst_word_t            inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]       imm,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic                  src_a_pc,
    output logic                  src_a_zero,
    output logic                  src_b_imm,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  writes_rd,
    output logic                  is_halt,
    output logic [2:0]            funct3
);

    logic [6:0]          opcode;
    logic [6:0]          f7;
    logic [ALU_OP_W-1:0] alu_sel;
    logic [XLEN-1:0]     imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = inst.r.opcode;
    assign f7     = inst.r.funct7;
    assign rs1    = inst.i.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_s = {{(XLEN-12){f7[6]}}, f7, inst.r.rd};
    assign imm_b = {{(XLEN-12){f7[6]}}, inst.r.rd[0], f7[5:0], inst.r.rd[4:1], 1'b0};
    assign imm_u = {f7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'h000};
    assign imm_j = {{(XLEN-20){f7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                    f7[5:0], inst.r.rs2[4:1], 1'b0};

    // funct3/funct7 to ALU op, SUB only exists in register form
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (opcode == OPC_OP && f7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = f7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    assign alu_op     = (opcode == OPC_OP || opcode == OPC_OP_IMM) ? alu_sel : ALU_ADD;
    assign src_a_pc   = opcode == OPC_AUIPC || opcode == OPC_JAL;
    assign src_a_zero = opcode == OPC_LUI;
    assign src_b_imm  = opcode != OPC_OP && opcode != OPC_BRANCH;
    assign is_branch  = opcode == OPC_BRANCH;
    assign is_jal     = opcode == OPC_JAL;
    assign is_jalr    = opcode == OPC_JALR;
    assign is_load    = opcode == OPC_LOAD;
    assign is_store   = opcode == OPC_STORE;
    assign writes_rd  = opcode == OPC_OP || opcode == OPC_OP_IMM || opcode == OPC_LOAD
                     || opcode == OPC_JAL || opcode == OPC_JALR
                     || opcode == OPC_LUI || opcode == OPC_AUIPC;
    // ebreak only, other system encodings fall through as no-ops
    assign is_halt    = opcode == OPC_SYSTEM && inst.i.imm12 == 12'h001
                     && funct3 == 3'b000 && inst.i.rs1 == '0 && inst.i.rd == '0;

    always_comb begin
        case (opcode)
            OPC_STORE:            imm = imm_s;
            OPC_BRANCH:           imm = imm_b;
            OPC_LUI, OPC_AUIPC:   imm = imm_u;
            OPC_JAL:              imm = imm_j;
            default:              imm = imm_i;   // op-imm, load, jalr, system
        endcase
    end

endmodule

//--- source/execute_unit.sv
// ALU, branch compare and next-PC selection for the current instruction
// purely combinational, results are sampled by the sequencer
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    input  logic [XLEN-1:0]     imm,
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic                src_a_pc,
    input  logic                src_a_zero,
    input  logic                src_b_imm,
    input  logic                is_branch,
    input  logic                is_jal,
    input  logic                is_jalr,
    input  logic [2:0]          funct3,
    output logic [XLEN-1:0]     alu_result,
    output logic [XLEN-1:0]     next_pc,
    output logic [XLEN-1:0]     wb_data
);

    logic [XLEN-1:0] op_a, op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;    // branch and jal target
    logic            taken;

    assign op_a  = src_a_zero ? '0 : (src_a_pc ? pc : rs1_data);
    assign op_b  = src_b_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch condition always compares the two registers
    always_comb begin
        case (funct3)
            3'b000:  taken = rs1_data == rs2_data;                      // beq
            3'b001:  taken = rs1_data != rs2_data;                      // bne
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);     // blt
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);    // bge
            3'b110:  taken = rs1_data < rs2_data;                       // bltu
            3'b111:  taken = rs1_data >= rs2_data;                      // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm;

    always_comb begin
        if (is_jalr)
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        else if (is_jal || (is_branch && taken))
            next_pc = target;
        else
            next_pc = pc_plus4;
    end

    assign wb_data = (is_jal || is_jalr) ? pc_plus4 : alu_result;   // link value

endmodule

//--- source/core_sequencer.sv
// fetch/exec/mem state machine with PC, instruction register and bus handshake
// also lines up store lanes, extracts load lanes and drives the register write port
`timescale 1ns/1ps

module core_sequencer import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_ack,
    input  logic [XLEN-1:0]       mem_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    output logic [3:0]            mem_wstrb,
    output inst_word_t            inst,
    output logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       next_pc,
    input  logic [XLEN-1:0]       alu_result,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic [XLEN-1:0]       wb_data,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic                  writes_rd,
    input  logic                  is_halt,
    input  logic [2:0]            mem_size,
    input  logic [REG_ADDR_W-1:0] rd,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic                  halted
);

    logic [STATE_W-1:0] state;
    logic [XLEN-1:0]    load_word;   // raw word from the data read
    logic [XLEN-1:0]    load_lane;
    logic [XLEN-1:0]    load_value;
    logic [XLEN-1:0]    store_data;
    logic [3:0]         store_strb;
    logic [1:0]         byte_off;
    logic               launch_fetch, launch_mem;

    assign byte_off = alu_result[1:0];

    // new request only ever starts with ack already low
    assign launch_fetch = (state == ST_FETCH_REQ && !mem_req && !mem_ack)
                       || (state == ST_EXEC && !is_halt && !is_load && !is_store)
                       || (state == ST_MEM_REL && !mem_ack);
    assign launch_mem   = state == ST_EXEC && !is_halt && (is_load || is_store);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_FETCH_REQ;
            pc      <= RESET_PC;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            halted  <= 1'b0;
        end else begin
            if (launch_fetch) mem_req <= 1'b1;
            case (state)
                ST_FETCH_REQ: if (mem_req && mem_ack) begin
                    mem_req <= 1'b0;
                    state   <= ST_FETCH_REL;
                end
                ST_FETCH_REL: if (!mem_ack) state <= ST_EXEC;
                ST_EXEC: begin
                    if (is_halt) begin
                        halted <= 1'b1;
                        state  <= ST_HALT;
                    end else if (launch_mem) begin
                        mem_req <= 1'b1;
                        mem_we  <= is_store;
                        state   <= ST_MEM_REQ;
                    end else begin
                        pc    <= next_pc;
                        state <= ST_FETCH_REQ;
                    end
                end
                ST_MEM_REQ: if (mem_ack) begin
                    mem_req <= 1'b0;
                    state   <= ST_MEM_REL;
                end
                ST_MEM_REL: if (!mem_ack) begin
                    pc     <= next_pc;   // pc+4, inst and regs still stable here
                    mem_we <= 1'b0;
                    state  <= ST_FETCH_REQ;
                end
                default: ;               // halted, wait for reset
            endcase
        end
    end

    // bus payload and captured words
    always_ff @(posedge clk) begin
        if (launch_fetch) begin
            mem_addr  <= (state == ST_FETCH_REQ) ? pc : next_pc;
            mem_wstrb <= 4'b0000;
        end else if (launch_mem) begin
            mem_addr  <= {alu_result[XLEN-1:2], 2'b00};
            mem_wdata <= store_data;
            mem_wstrb <= is_store ? store_strb : 4'b0000;
        end
        if (state == ST_FETCH_REQ && mem_req && mem_ack) inst <= mem_rdata;
        if (state == ST_MEM_REQ && mem_ack) load_word <= mem_rdata;
    end

    // store lane placement
    always_comb begin
        store_data = rs2_data << {byte_off, 3'b000};
        case (mem_size)
            SIZE_B:  store_strb = 4'b0001 << byte_off;
            SIZE_H:  store_strb = 4'b0011 << byte_off;
            default: store_strb = 4'b1111;
        endcase
    end

    always_comb begin
        load_lane = load_word >> {byte_off, 3'b000};
        case (mem_size)
            SIZE_B:  load_value = {{(XLEN-8){load_lane[7]}}, load_lane[7:0]};
            SIZE_H:  load_value = {{(XLEN-16){load_lane[15]}}, load_lane[15:0]};
            SIZE_BU: load_value = {{(XLEN-8){1'b0}}, load_lane[7:0]};
            SIZE_HU: load_value = {{(XLEN-16){1'b0}}, load_lane[15:0]};
            default: load_value = load_lane;   // word
        endcase
    end

    // loads write when ack falls, everything else in exec
    assign rf_we    = writes_rd && (rd != '0)
                   && ((state == ST_EXEC && !is_load)
                    || (state == ST_MEM_REL && !mem_ack && is_load));
    assign rf_waddr = rd;
    assign rf_wdata = is_load ? load_value : wb_data;

endmodule

//--- source/rv_core.sv
// multicycle RV32I core top, one four-phase req/ack bus for fetch and data
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_ack,
    input  logic [XLEN-1:0] mem_rdata,
    output logic            mem_req,
    output logic            mem_we,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    output logic [3:0]      mem_wstrb,
    output logic            halted
);

    inst_word_t            inst;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       imm;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [2:0]            funct3;
    logic src_a_pc, src_a_zero, src_b_imm;
    logic is_branch, is_jal, is_jalr, is_load, is_store, writes_rd, is_halt;

    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic [XLEN-1:0]       alu_result, next_pc, wb_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    core_sequencer i_sequencer (
        .clk(clk), .reset(reset),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .inst(inst), .pc(pc),
        .next_pc(next_pc), .alu_result(alu_result), .rs2_data(rs2_data), .wb_data(wb_data),
        .is_load(is_load), .is_store(is_store), .writes_rd(writes_rd), .is_halt(is_halt),
        .mem_size(funct3), .rd(rd),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .halted(halted)
    );

    inst_decoder i_decoder (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .src_a_pc(src_a_pc), .src_a_zero(src_a_zero), .src_b_imm(src_b_imm),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_load(is_load), .is_store(is_store), .writes_rd(writes_rd), .is_halt(is_halt),
        .funct3(funct3)
    );

    reg_file i_reg_file (
        .clk(clk), .reset(reset),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    execute_unit i_execute (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
        .src_a_pc(src_a_pc), .src_a_zero(src_a_zero), .src_b_imm(src_b_imm),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .funct3(funct3),
        .alu_result(alu_result), .next_pc(next_pc), .wb_data(wb_data)
    );

endmodule

//--- testbench/mem_model.sv
// word memory answering the core's four-phase bus
// ack rises and falls 0 to 3 cycles late when rand_delay is set, otherwise right away
`timescale 1ns/1ps

module mem_model import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            rand_delay,
    input  logic            mem_req,
    input  logic            mem_we,
    input  logic [XLEN-1:0] mem_addr,
    input  logic [XLEN-1:0] mem_wdata,
    input  logic [3:0]      mem_wstrb,
    output logic            mem_ack,
    output logic [XLEN-1:0] mem_rdata
);

    logic [XLEN-1:0] mem [1024];   // 4 KiB of words
    logic            ack = 1'b0;
    logic [XLEN-1:0] rdata = '0;
    logic            busy = 1'b0;
    int              wait_cnt = 0;
    int              seed = 85;

    assign mem_ack   = ack;
    assign mem_rdata = rdata;

    always @(posedge clk) begin
        #1;
        if (reset) begin
            ack  = 1'b0;
            busy = 1'b0;
        end else if (ack) begin
            if (!mem_req) begin   // last phase of the handshake
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = rand_delay ? ($random(seed) & 3) : 0;
                end
                if (wait_cnt == 0) begin
                    ack  = 1'b0;
                    busy = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end else if (mem_req) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = rand_delay ? ($random(seed) & 3) : 0;
            end
            if (wait_cnt == 0) begin
                if (mem_we) begin
                    for (int i = 0; i < 4; i++)
                        if (mem_wstrb[i]) mem[mem_addr[11:2]][8*i +: 8] = mem_wdata[8*i +: 8];
                end
                rdata = mem[mem_addr[11:2]];
                ack   = 1'b1;
                busy  = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    end

endmodule

//--- testbench/rv_asm.svh
// RV32I instruction encoders for building test programs in the testbench
// include inside a module that imports rv_pkg
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

`endif

//--- testbench/tb_rv_core.sv
// directed testbench for rv_core, programs are encoded straight into the memory model
// each test runs a program to EBREAK and checks the words its stores left behind
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    `include "rv_asm.svh"

    localparam logic [31:0] A_VAL     = 32'h8000_1234;
    localparam logic [31:0] B_VAL     = 32'hFFFF_FFF3;
    localparam logic [31:0] LOAD_WORD = 32'hF08C_7A35;
    localparam logic [31:0] STORE_VAL = 32'hCAFE_BABE;

    logic clk = 1'b0;
    logic reset;
    logic rand_delay;
    logic mem_req, mem_we, mem_ack, halted;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic [3:0]  mem_wstrb;

    int errors = 0;
    int checks = 0;
    int wp;                      // next program word
    int n_exp;
    logic [11:0] st_off;
    logic [31:0] exp_w [64];     // expected words from 0x400 up

    logic        prev_req = 1'b0;
    logic        prev_ack = 1'b0;
    logic        prev_we;
    logic [31:0] prev_addr, prev_wdata;
    logic [3:0]  prev_strb;

    always #5 clk = ~clk;

    rv_core i_dut (
        .clk(clk), .reset(reset), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .halted(halted)
    );

    mem_model i_mem (
        .clk(clk), .reset(reset), .rand_delay(rand_delay), .mem_req(mem_req),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    // bus protocol monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (mem_req && !prev_req)
                assert (!prev_ack) else begin
                    errors++;
                    $display("bus protocol: mem_req rose while mem_ack was still high");
                end
            if (mem_req)
                assert (mem_addr[1:0] == 2'b00) else begin
                    errors++;
                    $display("** Error: mem_addr = 0x%08h is not word aligned", mem_addr);
                end
            if (mem_req && prev_req)
                assert (mem_addr == prev_addr && mem_we == prev_we
                        && mem_wdata == prev_wdata && mem_wstrb == prev_strb) else begin
                    errors++;
                    $display("bus protocol: bus outputs changed while mem_req was held");
                end
        end
        prev_req   <= mem_req;
        prev_ack   <= mem_ack;
        prev_we    <= mem_we;
        prev_addr  <= mem_addr;
        prev_wdata <= mem_wdata;
        prev_strb  <= mem_wstrb;
    end

    // reference rules from the RV32I spec
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] w,
            input int off);
        logic [31:0] sh;
        sh = w >> (8 * off);
        case (f3)
            SIZE_B:  return {{24{sh[7]}}, sh[7:0]};
            SIZE_BU: return {24'd0, sh[7:0]};
            SIZE_H:  return {{16{sh[15]}}, sh[15:0]};
            SIZE_HU: return {16'd0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] val,
            input int nbytes, input int off);
        logic [31:0] r;
        r = old;
        for (int i = 0; i < nbytes; i++) r[8*(off+i) +: 8] = val[8*i +: 8];
        return r;
    endfunction

    task automatic emit(input logic [31:0] w);
        i_mem.mem[wp] = w;
        wp++;
    endtask

    task automatic push_exp(input logic [31:0] v);
        exp_w[n_exp] = v;
        n_exp++;
    endtask

    task automatic store_x4();
        emit(s_type(st_off, 5'd4, 5'd3, SIZE_W));
        st_off += 12'd4;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [19:0] up;
        up = 20'((val + 32'h800) >> 12);   // addi sign-extends the low part
        emit(u_type(up, rd, OPC_LUI));
        emit(i_type(val[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    // reset held while the next program is written
    task automatic hold_reset(input logic random_ack);
        @(posedge clk);
        #1;
        reset      = 1'b1;
        rand_delay = random_ack;
        for (int i = 0; i < 1024; i++) i_mem.mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;
        wp     = 0;
        n_exp  = 0;
        st_off = 12'd0;
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));   // x3 = result base
    endtask

    task automatic run_program(input string tag);
        int cyc;
        emit(32'h0010_0073);   // ebreak
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        cyc = 0;
        while (!halted && cyc < 20000) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!halted) begin
            errors++;
            $display("timeout: %s program never reached halted", tag);
        end
        for (int k = 0; k < n_exp; k++) begin
            checks++;
            assert (i_mem.mem[256+k] === exp_w[k]) else begin
                errors++;
                $display("** Error: %s mem[0x%03h] = 0x%08h, expected 0x%08h",
                         tag, 1024 + 4*k, i_mem.mem[256+k], exp_w[k]);
            end
        end
    endtask

    task automatic rr_op(input logic [2:0] f3, input logic [6:0] f7);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd4, OPC_OP));
        push_exp(alu_ref(f3, f7[5], A_VAL, B_VAL));
        store_x4();
    endtask

    task automatic ri_op(input logic [2:0] f3, input logic [11:0] imm);
        emit(i_type(imm, 5'd1, f3, 5'd4, OPC_OP_IMM));
        push_exp(alu_ref(f3, f3 == 3'b101 && imm[10], A_VAL, {{20{imm[11]}}, imm}));
        store_x4();
    endtask

    task automatic run_alu_test(input logic random_ack, input string tag);
        logic [31:0] p;
        hold_reset(random_ack);
        load_const(5'd1, A_VAL);
        load_const(5'd2, B_VAL);
        for (int f = 0; f < 8; f++) rr_op(3'(f), 7'h00);
        rr_op(3'b000, 7'h20);   // sub
        rr_op(3'b101, 7'h20);   // sra
        ri_op(3'b000, 12'hFFB);
        ri_op(3'b010, 12'h800);
        ri_op(3'b011, 12'h005);
        ri_op(3'b100, 12'h5A5);
        ri_op(3'b110, 12'h0F0);
        ri_op(3'b111, 12'h8F0);
        ri_op(3'b001, 12'h004);
        ri_op(3'b101, 12'h008);
        ri_op(3'b101, 12'h408); // srai
        emit(u_type(20'hABCDE, 5'd4, OPC_LUI));
        push_exp(32'hABCD_E000);
        store_x4();
        p = wp * 4;
        emit(u_type(20'h00001, 5'd4, OPC_AUIPC));
        push_exp(p + 32'h1000);
        store_x4();
        run_program(tag);
    endtask

    task automatic run_branch_test();
        logic [4:0]  r1, r2;
        logic [31:0] va, vb, p;
        int          slot;
        hold_reset(1'b0);
        for (int k = 0; k < 32; k++) begin
            i_mem.mem[256+k] = 32'hDEAD_0000 | k;
            exp_w[k] = 32'hDEAD_0000 | k;
        end
        n_exp = 32;
        load_const(5'd1, 32'd5);
        load_const(5'd2, 32'hFFFF_FFFD);
        slot = 0;
        for (int pr = 0; pr < 3; pr++) begin
            for (int f = 0; f < 8; f++) begin
                if (f != 2 && f != 3) begin
                    r1 = (pr == 1) ? 5'd2 : 5'd1;
                    r2 = (pr == 0) ? 5'd2 : 5'd1;
                    va = (r1 == 5'd1) ? 32'd5 : 32'hFFFF_FFFD;
                    vb = (r2 == 5'd1) ? 32'd5 : 32'hFFFF_FFFD;
                    emit(i_type(12'(slot + 1), 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
                    emit(b_type(13'd8, r2, r1, 3'(f)));   // taken skips the marker store
                    emit(s_type(12'(slot * 4), 5'd6, 5'd3, SIZE_W));
                    if (!branch_ref(3'(f), va, vb)) exp_w[slot] = 32'(slot + 1);
                    slot++;
                end
            end
        end
        emit(i_type(12'h0AA, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        p = wp * 4;
        emit(j_type(21'd8, 5'd8));
        emit(s_type(12'd72, 5'd6, 5'd3, SIZE_W));
        emit(s_type(12'd76, 5'd8, 5'd3, SIZE_W));
        exp_w[19] = p + 32'd4;
        p = wp * 4;
        emit(i_type(12'(p + 32'd13), 5'd0, 3'b000, 5'd9, OPC_OP_IMM));   // odd target
        emit(i_type(12'h000, 5'd9, 3'b000, 5'd10, OPC_JALR));
        emit(s_type(12'd80, 5'd6, 5'd3, SIZE_W));
        emit(s_type(12'd84, 5'd10, 5'd3, SIZE_W));
        exp_w[21] = p + 32'd8;
        run_program("branch");
    endtask

    task automatic run_load_test();
        logic [2:0] f3;
        int         step;
        hold_reset(1'b0);
        i_mem.mem[320] = LOAD_WORD;
        emit(i_type(12'h500, 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
        for (int s = 0; s < 5; s++) begin
            case (s)
                0:       f3 = SIZE_B;
                1:       f3 = SIZE_BU;
                2:       f3 = SIZE_H;
                3:       f3 = SIZE_HU;
                default: f3 = SIZE_W;
            endcase
            step = (f3 == SIZE_W) ? 4 : ((f3 == SIZE_H || f3 == SIZE_HU) ? 2 : 1);
            for (int off = 0; off < 4; off += step) begin
                emit(i_type(12'(off), 5'd11, f3, 5'd4, OPC_LOAD));
                push_exp(load_ref(f3, LOAD_WORD, off));
                store_x4();
            end
        end
        run_program("load");
    endtask

    task automatic run_store_test();
        hold_reset(1'b0);
        for (int k = 0; k < 6; k++) begin
            i_mem.mem[256+k] = 32'h0F1E_2D3C ^ (k * 32'h1111_1111);
            exp_w[k] = 32'h0F1E_2D3C ^ (k * 32'h1111_1111);
        end
        n_exp = 6;
        load_const(5'd12, STORE_VAL);
        for (int off = 0; off < 4; off++) begin
            emit(s_type(12'(5 * off), 5'd12, 5'd3, SIZE_B));   // byte off of word off
            exp_w[off] = merge(exp_w[off], STORE_VAL, 1, off);
        end
        for (int h = 0; h < 2; h++) begin
            emit(s_type(12'(16 + 6 * h), 5'd12, 5'd3, SIZE_H));
            exp_w[4+h] = merge(exp_w[4+h], STORE_VAL, 2, 2 * h);
        end
        run_program("store");
    endtask

    task automatic check_halt();
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            #1;
            checks++;
            assert (halted && !mem_req) else begin
                errors++;
                $display("** Error: halted = 0x%h mem_req = 0x%h after EBREAK", halted, mem_req);
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        rand_delay = 1'b0;
        run_alu_test(1'b0, "alu");
        run_branch_test();
        run_load_test();
        run_store_test();
        run_alu_test(1'b1, "alu random ack");
        check_halt();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+testbench
source/rv_pkg.sv
source/reg_file.sv
source/inst_decoder.sv
source/execute_unit.sv
source/core_sequencer.sv
source/rv_core.sv
testbench/mem_model.sv
testbench/tb_rv_core.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_rv_core
FILELIST   = sources.f
PASS_MSG   = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
